// ==== compile.f ====
verilog/ctrl_pkg.sv
verilog/ctrl_exc_detect.sv
verilog/ctrl_irq_arbiter.sv
verilog/ctrl_fsm.sv
verilog/ctrl_top.sv
verification/tb_clock.sv
verification/tb_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the controller testbench with Verilator and run it.
# The exit status is the simulator's, so a failing run fails the script.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_ctrl \
  -f compile.f \
  -o sim_ctrl

./obj_dir/sim_ctrl

// ==== verification/tb_clock.sv ====
/*
  Clock and reset source for the controller testbench.
  100 ns clock, active low reset held for the first two rising edges.
*/
`default_nettype none
`timescale 1ns/1ns

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  // release reset a little after the second edge, like any other input
  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #10;
    rst_no = 1'b1;
  end

  always #50 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== verification/tb_ctrl.sv ====
/*
  Testbench for the pipeline controller. Runs boot, exceptions, branches,
  interrupts, NMI nesting, back-pressure and WFI sleep through the DUT and
  checks each pc redirect against a reference model of the trap rules.
*/
`default_nettype none
`timescale 1ns/1ns

module tb_ctrl;

  import ctrl_pkg::*;

  localparam int timeout_cycles = 50;

  // what one redirect must carry into the CSR file
  typedef struct packed {
    exc_cause_u  cause;
    logic [31:0] mtval;
  } trap_t;

  logic          clk;
  logic          rst_n;
  logic          fetch_enable;
  logic          instr_valid;
  decode_flags_t dec;
  instr_info_t   instr;
  logic          stall_id;
  irqs_t         irqs;
  logic          irq_nm;
  logic          irq_pending;
  logic          mie;
  logic          nmi_mode;
  logic          ctrl_busy;
  logic          controller_run;
  logic          instr_req;
  logic          pc_set;
  pc_sel_e       pc_mux;
  exc_pc_sel_e   exc_pc_mux;
  csr_ctrl_t     csr;
  logic          id_in_ready;
  logic          instr_valid_clear;
  logic          flush_id;

  // expectation shared between stimulus and compare process
  trap_t         exp_trap;
  pc_sel_e       exp_src;
  exc_pc_sel_e   exp_vec;
  logic          armed;
  logic          exp_seen;
  logic [31:0]   rng;

  tb_clock u_clock (.clk_o(clk), .rst_no(rst_n));

  ctrl_top UUT (
    .clk_i (clk), .rst_ni (rst_n), .fetch_enable_i (fetch_enable),
    .instr_valid_i (instr_valid), .dec_i (dec), .instr_i (instr), .stall_id_i (stall_id),
    .irqs_i (irqs), .irq_nm_i (irq_nm), .irq_pending_i (irq_pending), .mie_i (mie),
    .nmi_mode_o (nmi_mode), .ctrl_busy_o (ctrl_busy), .controller_run_o (controller_run),
    .instr_req_o (instr_req), .pc_set_o (pc_set), .pc_mux_o (pc_mux),
    .exc_pc_mux_o (exc_pc_mux), .csr_o (csr), .id_in_ready_o (id_in_ready),
    .instr_valid_clear_o (instr_valid_clear), .flush_id_o (flush_id)
  );

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // reference model built straight from the cause and mtval rules
  function automatic trap_t expected_trap(input logic is_irq, input decode_flags_t d,
                                          input instr_info_t ii, input irqs_t v,
                                          input logic nmi);
    trap_t t;
    int    top;
    t.cause.raw = 6'd0;
    t.mtval     = 32'd0;
    top         = -1;
    if (is_irq) begin
      t.cause.fields.irq = 1'b1;
      // search down from the top fast line
      for (int i = 14; i >= 0; i--) begin
        if (v.fast[i] && top < 0) begin
          top = i;
        end
      end
      if (nmi) t.cause.fields.code = 5'd31;
      else if (top >= 0) t.cause.fields.code = 5'(16 + top);
      else if (v.external) t.cause.fields.code = 5'd11;
      else if (v.software) t.cause.fields.code = 5'd3;
      else if (v.timer) t.cause.fields.code = 5'd7;
    end else if (d.fetch_err) begin
      t.cause.fields.code = 5'd1;
      t.mtval = d.fetch_err_plus2 ? ii.pc_id + 32'd2 : ii.pc_id;
    end else if (d.illegal) begin
      t.cause.fields.code = 5'd2;
      t.mtval = d.is_compressed ? {16'd0, ii.instr_compressed} : ii.instr;
    end else if (d.ecall) begin
      t.cause.fields.code = 5'd11;
    end else if (d.ebreak) begin
      t.cause.fields.code = 5'd3;
    end
    return t;
  endfunction

  task automatic abort(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic next_cycle;
    @(posedge clk);
    #10;
  endtask

  task automatic random_instr(output instr_info_t ii);
    rng = xorshift(rng);
    ii.instr = rng;
    rng = xorshift(rng);
    ii.instr_compressed = rng[15:0];
    rng = xorshift(rng);
    ii.pc_id = {rng[31:1], 1'b0};
  endtask

  // ends on a falling edge with the FSM in DECODE
  task automatic wait_decode;
    int n;
    n = 0;
    @(negedge clk);
    while (!controller_run) begin
      n++;
      if (n > timeout_cycles) abort("timed out waiting for the controller to reach DECODE");
      @(negedge clk);
    end
  endtask

  task automatic await_redirect;
    int n;
    n = 0;
    while (!exp_seen) begin
      if (n == timeout_cycles) abort("timed out waiting for the expected pc_set_o");
      n++;
      next_cycle();
    end
  endtask

  // one instruction in ID with its flags held until the redirect is seen
  task automatic decode_case(input decode_flags_t d, input instr_info_t ii,
                             input pc_sel_e src);
    wait_decode();
    next_cycle();
    instr_valid = 1'b1;
    dec         = d;
    instr       = ii;
    exp_trap    = expected_trap(1'b0, d, ii, '0, 1'b0);
    exp_src     = src;
    exp_vec     = EXC_PC_EXC;
    exp_seen    = 1'b0;
    armed       = 1'b1;
    await_redirect();
    instr_valid = 1'b0;
    dec         = '0;
  endtask

  task automatic irq_case(input irqs_t v, input logic nmi);
    wait_decode();
    next_cycle();
    irqs        = v;
    irq_nm      = nmi;
    irq_pending = |v;
    mie         = 1'b1;
    exp_trap    = expected_trap(1'b1, '0, '0, v, nmi);
    exp_src     = PC_EXC;
    exp_vec     = EXC_PC_IRQ;
    exp_seen    = 1'b0;
    armed       = 1'b1;
    await_redirect();
    irqs        = '0;
    irq_nm      = 1'b0;
    irq_pending = 1'b0;
  endtask

  ////////////////////
  // compare
  ////////////////////

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (armed && pc_set) begin
      check("pc_mux_o", 32'(pc_mux), 32'(exp_src));
      if (exp_src == PC_EXC) begin
        check("exc_pc_mux_o", 32'(exc_pc_mux), 32'(exp_vec));
        check("csr_o.cause", 32'(csr.cause.raw), 32'(exp_trap.cause.raw));
        check("csr_o.mtval", csr.mtval, exp_trap.mtval);
        check("csr_o.save_cause", 32'(csr.save_cause), 32'd1);
        if (exp_vec == EXC_PC_IRQ) check("csr_o.save_if", 32'(csr.save_if), 32'd1);
        else check("csr_o.save_id", 32'(csr.save_id), 32'd1);
      end
      if (exp_src == PC_ERET) check("csr_o.restore_mret", 32'(csr.restore_mret), 32'd1);
      // exception and mret redirects come from FLUSH, which empties ID
      if (exp_src == PC_ERET || (exp_src == PC_EXC && exp_vec == EXC_PC_EXC)) begin
        check("flush_id_o", 32'(flush_id), 32'd1);
        check("instr_valid_clear_o", 32'(instr_valid_clear), 32'd1);
      end
      armed    = 1'b0;
      exp_seen = 1'b1;
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin : main
    decode_flags_t d;
    instr_info_t   ii;
    irqs_t         v;
    int            n;
    fetch_enable = 1'b0;
    instr_valid  = 1'b0;
    dec          = '0;
    instr        = '0;
    stall_id     = 1'b0;
    irqs         = '0;
    irq_nm       = 1'b0;
    irq_pending  = 1'b0;
    mie          = 1'b0;
    armed        = 1'b0;
    exp_seen     = 1'b0;
    exp_trap     = '0;
    exp_src      = PC_BOOT;
    exp_vec      = EXC_PC_EXC;
    rng          = 32'hd5a1;

    n = 0;
    while (rst_n !== 1'b1) begin
      n++;
      if (n > timeout_cycles) abort("reset was never released");
      @(posedge clk);
    end

    // boot address held in RESET with no fetch yet
    @(negedge clk);
    check("pc_set_o", 32'(pc_set), 32'd1);
    check("pc_mux_o", 32'(pc_mux), 32'(PC_BOOT));
    check("instr_req_o", 32'(instr_req), 32'd0);
    next_cycle();
    fetch_enable = 1'b1;
    n = 0;
    @(negedge clk);
    while (!instr_req) begin
      n++;
      if (n > timeout_cycles) abort("timed out waiting for instr_req_o after fetch enable");
      @(negedge clk);
    end
    check("pc_set_o", 32'(pc_set), 32'd1);
    check("pc_mux_o", 32'(pc_mux), 32'(PC_BOOT));

    // illegal instructions and fetch errors
    for (int k = 0; k < 8; k++) begin
      random_instr(ii);
      rng = xorshift(rng);
      d = '0;
      d.fetch_err       = (rng[1:0] < 2'd2);
      d.illegal         = (rng[1:0] != 2'd0);
      d.fetch_err_plus2 = rng[2];
      d.is_compressed   = rng[3];
      decode_case(d, ii, PC_EXC);
    end
    // the fetch error wins over an illegal flag on the upper half
    random_instr(ii);
    d = '0;
    d.fetch_err       = 1'b1;
    d.fetch_err_plus2 = 1'b1;
    d.illegal         = 1'b1;
    decode_case(d, ii, PC_EXC);

    // ecall, ebreak, branch, branch blocked by an illegal flag
    random_instr(ii);
    d = '0;
    d.ecall = 1'b1;
    decode_case(d, ii, PC_EXC);
    d = '0;
    d.ebreak = 1'b1;
    decode_case(d, ii, PC_EXC);
    d = '0;
    d.branch_jump = 1'b1;
    decode_case(d, ii, PC_JUMP);
    d.illegal = 1'b1;
    decode_case(d, ii, PC_EXC);

    // random interrupt mixes
    for (int k = 0; k < 8; k++) begin
      rng = xorshift(rng);
      v.fast     = (rng[16:15] == 2'b00) ? rng[14:0] : 15'd0;
      v.external = rng[17];
      v.software = rng[18];
      v.timer    = rng[19];
      if (v == '0) v.timer = 1'b1;
      irq_case(v, 1'b0);
    end

    // nothing may be taken while masked by mie
    wait_decode();
    next_cycle();
    irqs.timer  = 1'b1;
    irq_pending = 1'b1;
    mie         = 1'b0;
    repeat (20) begin
      @(negedge clk);
      check("pc_set_o", 32'(pc_set), 32'd0);
    end
    next_cycle();
    irqs        = '0;
    irq_pending = 1'b0;

    // NMI over other pending lines then a second NMI that must wait for MRET
    irq_case(v, 1'b1);
    @(negedge clk);
    check("nmi_mode_o", 32'(nmi_mode), 32'd1);
    next_cycle();
    irq_nm = 1'b1;
    repeat (20) begin
      @(negedge clk);
      check("pc_set_o", 32'(pc_set), 32'd0);
    end
    next_cycle();
    irq_nm = 1'b0;
    d = '0;
    d.mret = 1'b1;
    decode_case(d, ii, PC_ERET);
    @(negedge clk);
    check("nmi_mode_o", 32'(nmi_mode), 32'd0);

    // back-pressure holds the interrupt in DECODE
    wait_decode();
    next_cycle();
    stall_id    = 1'b1;
    irqs.timer  = 1'b1;
    irq_pending = 1'b1;
    mie         = 1'b1;
    repeat (10) begin
      @(negedge clk);
      check("id_in_ready_o", 32'(id_in_ready), 32'd0);
      check("instr_valid_clear_o", 32'(instr_valid_clear), 32'd0);
      check("pc_set_o", 32'(pc_set), 32'd0);
    end
    next_cycle();
    stall_id = 1'b0;
    v        = '0;
    v.timer  = 1'b1;
    exp_trap = expected_trap(1'b1, '0, '0, v, 1'b0);
    exp_src  = PC_EXC;
    exp_vec  = EXC_PC_IRQ;
    exp_seen = 1'b0;
    armed    = 1'b1;
    await_redirect();
    irqs        = '0;
    irq_pending = 1'b0;
    mie         = 1'b0;

    // WFI sleeps until an interrupt is pending
    wait_decode();
    next_cycle();
    instr_valid = 1'b1;
    dec         = '0;
    dec.wfi     = 1'b1;
    n = 0;
    @(negedge clk);
    while (ctrl_busy) begin
      n++;
      if (n > timeout_cycles) abort("timed out waiting for ctrl_busy_o to fall after WFI");
      @(negedge clk);
    end
    next_cycle();
    instr_valid = 1'b0;
    dec         = '0;
    repeat (10) begin
      @(negedge clk);
      check("ctrl_busy_o", 32'(ctrl_busy), 32'd0);
      check("flush_id_o", 32'(flush_id), 32'd1);
    end
    next_cycle();
    irq_pending = 1'b1;
    n = 0;
    @(negedge clk);
    while (!ctrl_busy) begin
      n++;
      if (n > timeout_cycles) abort("timed out waiting for wake-up from sleep");
      @(negedge clk);
    end
    next_cycle();
    irq_pending = 1'b0;
    wait_decode();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/ctrl_exc_detect.sv ====
/*
  Exception and special request detection for the ID stage.
  Qualifies the decoder flags and registers the exception requests
  that the controller acts on in its FLUSH state.
*/
`default_nettype none
`timescale 1ns/1ns

module ctrl_exc_detect (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    instr_valid_i,
  input  wire ctrl_pkg::decode_flags_t dec_i,
  input  wire logic                    in_flush_i,
  output ctrl_pkg::exc_req_t           exc_o,
  output logic                         jump_req_o
);

  logic ecall;
  logic ebreak;
  logic mret;
  logic wfi;
  logic fetch_err;
  logic illegal_d;
  logic illegal_q;
  logic exc_req_d;
  logic exc_req_q;
  logic special_req_branch;

  ////////////////////
  // qualification
  ////////////////////

  // the decoder ignores instr valid, so factor it in here
  assign ecall     = dec_i.ecall & instr_valid_i;
  assign ebreak    = dec_i.ebreak & instr_valid_i;
  assign mret      = dec_i.mret & instr_valid_i;
  assign wfi       = dec_i.wfi & instr_valid_i;
  assign fetch_err = dec_i.fetch_err & instr_valid_i;

  // dropped while flushing so a handled request does not come back
  assign illegal_d = dec_i.illegal & instr_valid_i & ~in_flush_i;
  assign exc_req_d = (ecall | ebreak | illegal_d | fetch_err) & ~in_flush_i;

  // registered copies break the path from the decoder to pc_set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q <= 1'b0;
      exc_req_q <= 1'b0;
    end else begin
      illegal_q <= illegal_d;
      exc_req_q <= exc_req_d;
    end
  end

  ////////////////////
  // requests
  ////////////////////

  // only these reasons can stop a taken branch from setting the pc
  assign special_req_branch = (illegal_d | fetch_err) & ~in_flush_i;

  always_comb begin
    exc_o.ecall       = ecall;
    exc_o.ebreak      = ebreak;
    exc_o.mret        = mret;
    exc_o.wfi         = wfi;
    exc_o.fetch_err   = fetch_err;
    exc_o.exc_req_q   = exc_req_q;
    exc_o.illegal_q   = illegal_q;
    // any request that sends the controller to FLUSH
    exc_o.special_req = mret | wfi | exc_req_d;
  end

  assign jump_req_o = dec_i.branch_jump & instr_valid_i & ~special_req_branch;

  // a branch is never blocked without the controller also flushing
  branch_block_flushes: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    special_req_branch |-> exc_o.special_req
  );

endmodule

`default_nettype wire

// ==== verilog/ctrl_fsm.sv ====
/*
  Main controller state machine.
  Steps through boot, decode, flush, interrupt entry and sleep, and drives
  the pc, CSR save and IF-ID stall and flush controls from the current state.
*/
`default_nettype none
`timescale 1ns/1ns

module ctrl_fsm (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  fetch_enable_i,
  input  wire logic                  stall_id_i,
  input  wire ctrl_pkg::exc_req_t    exc_i,
  input  wire logic                  jump_req_i,
  input  wire logic                  handle_irq_i,
  input  wire logic                  irq_is_nmi_i,
  input  wire ctrl_pkg::exc_cause_u  irq_cause_i,
  input  wire ctrl_pkg::instr_info_t instr_i,
  // extra id stage flags needed for mtval and wake-up
  input  wire logic                  fetch_err_plus2_i,
  input  wire logic                  is_compressed_i,
  input  wire logic                  irq_nm_i,
  input  wire logic                  irq_pending_i,
  output logic                       in_flush_o,
  output logic                       nmi_mode_o,
  output logic                       ctrl_busy_o,
  output logic                       controller_run_o,
  output logic                       instr_req_o,
  output logic                       pc_set_o,
  output ctrl_pkg::pc_sel_e          pc_mux_o,
  output ctrl_pkg::exc_pc_sel_e      exc_pc_mux_o,
  output ctrl_pkg::csr_ctrl_t        csr_o,
  output logic                       id_in_ready_o,
  output logic                       instr_valid_clear_o,
  output logic                       flush_id_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        nmi_mode_q;
  logic        nmi_mode_d;
  logic        halt_if;
  logic        flush_id;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    // defaults, pc_mux only matters while pc_set is high
    instr_req_o       = 1'b1;
    pc_set_o          = 1'b0;
    pc_mux_o          = PC_BOOT;
    exc_pc_mux_o      = EXC_PC_IRQ;
    csr_o.save_if     = 1'b0;
    csr_o.save_id     = 1'b0;
    csr_o.save_cause  = 1'b0;
    csr_o.restore_mret = 1'b0;
    csr_o.cause.raw   = 6'd0;
    csr_o.mtval       = '0;
    ctrl_busy_o       = 1'b1;
    controller_run_o  = 1'b0;
    halt_if           = 1'b0;
    flush_id          = 1'b0;
    state_d           = state_q;
    nmi_mode_d        = nmi_mode_q;

    unique case (state_q)
      RESET: begin
        // hold the boot address until fetch is enabled
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      BOOT_SET: begin
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // wake on any pending irq, even when mie is clear
        if (irq_nm_i || irq_pending_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end

      FIRST_FETCH: begin
        // wait for the first instruction to reach ID
        if (!stall_id_i) begin
          state_d = DECODE;
        end
        if (handle_irq_i) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      DECODE: begin
        controller_run_o = 1'b1;
        pc_mux_o         = PC_JUMP;

        // keep the instruction in ID so FLUSH can inspect it
        if (exc_i.special_req) begin
          state_d = FLUSH;
          halt_if = 1'b1;
        end

        // taken branch or jump redirects in this same cycle
        if (jump_req_i) begin
          pc_set_o = 1'b1;
        end

        // irq waits for a stalled instruction, IF held meanwhile
        if (handle_irq_i && stall_id_i) begin
          halt_if = 1'b1;
        end

        if (!stall_id_i && !exc_i.special_req && handle_irq_i) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      IRQ_TAKEN: begin
        pc_mux_o     = PC_EXC;
        exc_pc_mux_o = EXC_PC_IRQ;
        // recheck, the request may have gone away meanwhile
        if (handle_irq_i) begin
          pc_set_o         = 1'b1;
          csr_o.save_if    = 1'b1;
          csr_o.save_cause = 1'b1;
          csr_o.cause      = irq_cause_i;
          if (irq_is_nmi_i) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end

      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;

        if (exc_i.exc_req_q) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          exc_pc_mux_o     = EXC_PC_EXC;
          csr_o.save_id    = 1'b1;
          csr_o.save_cause = 1'b1;

          // priority fetch error, illegal, ecall, ebreak
          if (exc_i.fetch_err) begin
            csr_o.cause.fields = '{irq: 1'b0, code: cause_instr_access_fault};
            // fault in the upper half of an unaligned fetch
            csr_o.mtval = fetch_err_plus2_i ? (instr_i.pc_id + xlen'(2)) : instr_i.pc_id;
          end else if (exc_i.illegal_q) begin
            csr_o.cause.fields = '{irq: 1'b0, code: cause_illegal_instr};
            csr_o.mtval = is_compressed_i ? {16'd0, instr_i.instr_compressed} : instr_i.instr;
          end else if (exc_i.ecall) begin
            csr_o.cause.fields = '{irq: 1'b0, code: cause_ecall_m};
          end else if (exc_i.ebreak) begin
            csr_o.cause.fields = '{irq: 1'b0, code: cause_breakpoint};
          end
        end else if (exc_i.mret) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = PC_ERET;
          csr_o.restore_mret = 1'b1;
          // returning from the handler also ends nmi mode
          nmi_mode_d         = 1'b0;
        end else if (exc_i.wfi) begin
          state_d = WAIT_SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

  ////////////////////
  // IF-ID controls
  ////////////////////

  assign in_flush_o = (state_q == FLUSH);
  assign nmi_mode_o = nmi_mode_q;
  assign flush_id_o = flush_id;

  // halt_if keeps instr valid set unless ID is also flushed
  assign id_in_ready_o       = ~stall_id_i & ~halt_if;
  assign instr_valid_clear_o = ~(stall_id_i | halt_if) | flush_id;

  state_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN}
  );

  // an interrupt redirect always records its cause
  irq_saves_cause: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == IRQ_TAKEN) && pc_set_o |-> csr_o.save_cause
  );

endmodule

`default_nettype wire

// ==== verilog/ctrl_irq_arbiter.sv ====
/*
  Interrupt arbiter of the controller.
  Decides whether an interrupt is taken and forms its mcause word.
*/
`default_nettype none
`timescale 1ns/1ns

module ctrl_irq_arbiter (
  input  wire ctrl_pkg::irqs_t  irqs_i,
  input  wire logic             irq_nm_i,
  input  wire logic             irq_pending_i,
  input  wire logic             mie_i,
  input  wire logic             nmi_mode_i,
  output logic                  handle_irq_o,
  output logic                  irq_is_nmi_o,
  output ctrl_pkg::exc_cause_u  irq_cause_o
);

  import ctrl_pkg::*;

  logic       fast_any;
  logic [3:0] fast_id;

  ////////////////////
  // take decision
  ////////////////////

  // no nesting inside an NMI handler, not even a second NMI
  assign handle_irq_o = ~nmi_mode_i & (irq_nm_i | (irq_pending_i & mie_i));
  assign irq_is_nmi_o = ~nmi_mode_i & irq_nm_i;

  ////////////////////
  // fast irq index
  ////////////////////

  // later indices overwrite earlier ones, so the highest set bit wins
  always_comb begin
    fast_any = 1'b0;
    fast_id  = 4'd0;
    for (int i = 0; i < num_fast_irqs; i++) begin
      if (irqs_i.fast[i]) begin
        fast_any = 1'b1;
        fast_id  = 4'(i);
      end
    end
  end

  ////////////////////
  // cause
  ////////////////////

  // priority nmi, fast, external, software, timer
  always_comb begin
    irq_cause_o.fields.irq = 1'b1;
    if (irq_nm_i) begin
      irq_cause_o.fields.code = cause_irq_nm;
    end else if (fast_any) begin
      // fast irq n maps to code 16 + n
      irq_cause_o.fields.code = cause_irq_fast_base + {1'b0, fast_id};
    end else if (irqs_i.external) begin
      irq_cause_o.fields.code = cause_irq_external;
    end else if (irqs_i.software) begin
      irq_cause_o.fields.code = cause_irq_software;
    end else if (irqs_i.timer) begin
      irq_cause_o.fields.code = cause_irq_timer;
    end else begin
      // nothing pending, the controller does not use the cause then
      irq_cause_o.fields.code = 5'd0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ctrl_pkg.sv ====
/*
  Shared types and constants of the pipeline controller.
  Each controller module imports what it needs from here.
*/
`default_nettype none

package ctrl_pkg;

  ////////////////////
  // widths
  ////////////////////

  // instruction and pc word width
  localparam int unsigned xlen          = 32;
  localparam int unsigned num_fast_irqs = 15;

  ////////////////////
  // cause codes
  ////////////////////

  // synchronous exceptions
  localparam logic [4:0] cause_instr_access_fault = 5'd1;
  localparam logic [4:0] cause_illegal_instr      = 5'd2;
  localparam logic [4:0] cause_breakpoint         = 5'd3;
  localparam logic [4:0] cause_ecall_m            = 5'd11;

  // interrupts, the fast ones count up from the base
  localparam logic [4:0] cause_irq_software  = 5'd3;
  localparam logic [4:0] cause_irq_timer     = 5'd7;
  localparam logic [4:0] cause_irq_external  = 5'd11;
  localparam logic [4:0] cause_irq_fast_base = 5'd16;
  localparam logic [4:0] cause_irq_nm        = 5'd31;

  ////////////////////
  // enums
  ////////////////////

  typedef enum logic [3:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_state_e;

  // pc source for the fetch stage
  typedef enum logic [1:0] {
    PC_BOOT, PC_JUMP, PC_EXC, PC_ERET
  } pc_sel_e;

  // vector used when pc_mux selects PC_EXC
  typedef enum logic {
    EXC_PC_EXC, EXC_PC_IRQ
  } exc_pc_sel_e;

  ////////////////////
  // structs
  ////////////////////

  typedef struct packed {
    logic       irq;
    logic [4:0] code;
  } exc_cause_t;

  // mcause word, raw or split into flag and code
  typedef union packed {
    logic [5:0] raw;
    exc_cause_t fields;
  } exc_cause_u;

  // decoder flags, not yet qualified with instr valid
  // branch_jump is a taken branch or a jump
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebreak;
    logic fetch_err;
    logic fetch_err_plus2;
    logic is_compressed;
    logic branch_jump;
  } decode_flags_t;

  typedef struct packed {
    logic                     software;
    logic                     timer;
    logic                     external;
    logic [num_fast_irqs-1:0] fast;
  } irqs_t;

  // id stage instruction, used for mtval
  typedef struct packed {
    logic [xlen-1:0] instr;
    logic [15:0]     instr_compressed;
    logic [xlen-1:0] pc_id;
  } instr_info_t;

  typedef struct packed {
    logic ecall;
    logic ebreak;
    logic mret;
    logic wfi;
    logic fetch_err;
    logic exc_req_q;
    logic illegal_q;
    logic special_req;
  } exc_req_t;

  typedef struct packed {
    logic            save_if;
    logic            save_id;
    logic            save_cause;
    logic            restore_mret;
    exc_cause_u      cause;
    logic [xlen-1:0] mtval;
  } csr_ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/ctrl_top.sv ====
/*
  Top level of the pipeline controller.
  Joins exception detection, interrupt arbitration and the state machine.
*/
`default_nettype none
`timescale 1ns/1ns

module ctrl_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    fetch_enable_i,
  // from the IF-ID register and decoder
  input  wire logic                    instr_valid_i,
  input  wire ctrl_pkg::decode_flags_t dec_i,
  input  wire ctrl_pkg::instr_info_t   instr_i,
  input  wire logic                    stall_id_i,
  // interrupts, already masked by mie
  input  wire ctrl_pkg::irqs_t         irqs_i,
  input  wire logic                    irq_nm_i,
  input  wire logic                    irq_pending_i,
  input  wire logic                    mie_i,
  // status
  output logic                         nmi_mode_o,
  output logic                         ctrl_busy_o,
  output logic                         controller_run_o,
  // to the prefetcher
  output logic                         instr_req_o,
  output logic                         pc_set_o,
  output ctrl_pkg::pc_sel_e            pc_mux_o,
  output ctrl_pkg::exc_pc_sel_e        exc_pc_mux_o,
  // to the CSR file
  output ctrl_pkg::csr_ctrl_t          csr_o,
  // to the IF-ID register
  output logic                         id_in_ready_o,
  output logic                         instr_valid_clear_o,
  output logic                         flush_id_o
);

  import ctrl_pkg::*;

  exc_req_t   exc;
  exc_cause_u irq_cause;
  logic       jump_req;
  logic       in_flush;
  logic       handle_irq;
  logic       irq_is_nmi;

  ctrl_exc_detect u_exc_detect (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .dec_i         (dec_i),
    .in_flush_i    (in_flush),
    .exc_o         (exc),
    .jump_req_o    (jump_req)
  );

  ctrl_irq_arbiter u_irq_arbiter (
    .irqs_i        (irqs_i),
    .irq_nm_i      (irq_nm_i),
    .irq_pending_i (irq_pending_i),
    .mie_i         (mie_i),
    .nmi_mode_i    (nmi_mode_o),
    .handle_irq_o  (handle_irq),
    .irq_is_nmi_o  (irq_is_nmi),
    .irq_cause_o   (irq_cause)
  );

  // mtval needs the fetch error half and the compressed flag from ID
  ctrl_fsm u_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_enable_i      (fetch_enable_i),
    .stall_id_i          (stall_id_i),
    .exc_i               (exc),
    .jump_req_i          (jump_req),
    .handle_irq_i        (handle_irq),
    .irq_is_nmi_i        (irq_is_nmi),
    .irq_cause_i         (irq_cause),
    .instr_i             (instr_i),
    .fetch_err_plus2_i   (dec_i.fetch_err_plus2),
    .is_compressed_i     (dec_i.is_compressed),
    .irq_nm_i            (irq_nm_i),
    .irq_pending_i       (irq_pending_i),
    .in_flush_o          (in_flush),
    .nmi_mode_o          (nmi_mode_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .controller_run_o    (controller_run_o),
    .instr_req_o         (instr_req_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .exc_pc_mux_o        (exc_pc_mux_o),
    .csr_o               (csr_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o)
  );

endmodule

`default_nettype wire
